// ==== Makefile ====
# Verilator build and run of the GPIO testbench

SRCS := $(filter-out +%,$(shell cat build.f)) include/gpio_regmap.svh

obj_dir/Vgpio_tb: $(SRCS) build.f
	verilator --binary --assert -j 0 --top-module gpio_tb -f build.f -o Vgpio_tb

run: obj_dir/Vgpio_tb
	./obj_dir/Vgpio_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== build.f ====
+incdir+include
verilog/gpio_pkg.sv
verilog/gpio_bus_if.sv
verilog/gpio_access.sv
verilog/gpio_regs.sv
verilog/gpio_input.sv
verilog/gpio.sv
sim/gpio_tb.sv

// ==== include/gpio_regmap.svh ====
// Word indexes of the GPIO register map, shared by the register file and the testbench
`ifndef GPIO_REGMAP_SVH
`define GPIO_REGMAP_SVH

// Byte address = word index * 4
// Index comes from address bits 5 to 2

// Pin direction, active low enable
`define GPIO_OEN    4'd0
// Output data, direct write
`define GPIO_OUT    4'd1
// Input enable per pin
`define GPIO_IEN    4'd2
// Synchronized input data, read only
`define GPIO_IN     4'd3
// Output data write aliases
`define GPIO_OUTAND 4'd4
`define GPIO_OUTORR 4'd5
`define GPIO_OUTXOR 4'd6
// Interrupt mask, set bit blocks the pin
`define GPIO_IMASK  4'd7

`endif

// ==== sim/gpio_tb.sv ====
// Directed testbench for the GPIO block, run as the simulation top with build.f
`timescale 1ns/1ns
`include "gpio_regmap.svh"

module gpio_tb;

   // Pin bits of a 24-pin block
   localparam gpio_pkg::data_t PIN_MASK = 32'h00ff_ffff;

   logic                clk;
   logic                nreset;
   logic                access_in;
   logic                write_in;
   gpio_pkg::addr_t     addr_in;
   gpio_pkg::data_t     data_in;
   logic                wait_out;
   logic                access_out;
   gpio_pkg::data_t     data_out;
   logic                wait_in;
   logic [23:0]         gpio_in;
   logic [23:0]         gpio_out;
   logic [23:0]         gpio_oen;
   logic [23:0]         gpio_data;
   logic                gpio_irq;

   logic [31:0]         lfsr = 32'h7c9e_f58f;
   int                  errors = 0;
   int                  checks = 0;
   int                  tests = 0;
   int                  mark;

   gpio #(.N(24)) u_gpio (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .write_in   (write_in),
      .addr_in    (addr_in),
      .data_in    (data_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .data_out   (data_out),
      .wait_in    (wait_in),
      .gpio_in    (gpio_in),
      .gpio_out   (gpio_out),
      .gpio_oen   (gpio_oen),
      .gpio_data  (gpio_data),
      .gpio_irq   (gpio_irq)
   );

   // 8 ns period
   always #4 clk = ~clk;

   // ##################################################
   // Helpers
   // ##################################################

   // Taps 32, 22, 2, 1; one step per bit
   function automatic gpio_pkg::data_t rand_bits(input int n);
      gpio_pkg::data_t v;
      logic            fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic gpio_pkg::addr_t addr_of(input gpio_pkg::regidx_t idx);
      return {2'b00, idx, 2'b00};
   endfunction

   task automatic check_value(input string name, input gpio_pkg::data_t got,
                              input gpio_pkg::data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      tests++;
      $display("Test %s finished with %0d errors", name, errors - start_errors);
   endtask

   // Wait_out looked at mid-cycle, request taken on the following edge
   task automatic wait_accept;
      logic stalled;
      stalled = 1'b1;
      while (stalled) begin
         @(negedge clk);
         stalled = wait_out;
         @(posedge clk);
      end
   endtask

   task automatic bus_write(input gpio_pkg::regidx_t idx, input gpio_pkg::data_t data);
      access_in <= 1'b1;
      write_in  <= 1'b1;
      addr_in   <= addr_of(idx);
      data_in   <= data;
      wait_accept();
      access_in <= 1'b0;
      write_in  <= 1'b0;
   endtask

   task automatic bus_read(input gpio_pkg::regidx_t idx, output gpio_pkg::data_t data);
      access_in <= 1'b1;
      write_in  <= 1'b0;
      addr_in   <= addr_of(idx);
      wait_accept();
      access_in <= 1'b0;
      // Response taken where it can be consumed
      do
         @(negedge clk);
      while (!(access_out && !wait_in));
      data = data_out;
      @(posedge clk);
   endtask

   // Flip one pin, count irq cycles over the next six
   task automatic toggle_pin(input int b, output int hits);
      gpio_in <= gpio_in ^ (24'd1 << b);
      hits = 0;
      repeat (6) begin
         @(negedge clk);
         if (gpio_irq)
            hits++;
      end
      @(posedge clk);
   endtask

   // ##################################################
   // Tests
   // ##################################################

   task automatic test_reset;
      gpio_pkg::data_t rd;
      @(negedge clk);
      check_value("gpio_oen", gpio_pkg::data_t'(gpio_oen), PIN_MASK);
      check_value("gpio_out", gpio_pkg::data_t'(gpio_out), 0);
      check_value("gpio_irq", gpio_pkg::data_t'(gpio_irq), 0);
      @(posedge clk);
      bus_read(`GPIO_IEN, rd);
      check_value("IEN read", rd, PIN_MASK);
      bus_read(`GPIO_IMASK, rd);
      check_value("IMASK read", rd, 0);
      bus_read(`GPIO_OEN, rd);
      check_value("OEN read", rd, PIN_MASK);
   endtask

   task automatic test_readback;
      gpio_pkg::data_t v;
      gpio_pkg::data_t rd;
      v = rand_bits(32);
      bus_write(`GPIO_OEN, v);
      @(negedge clk);
      check_value("gpio_oen", gpio_pkg::data_t'(gpio_oen), v & PIN_MASK);
      @(posedge clk);
      bus_read(`GPIO_OEN, rd);
      check_value("OEN read", rd, v & PIN_MASK);
      v = rand_bits(32);
      bus_write(`GPIO_OUT, v);
      @(negedge clk);
      check_value("gpio_out", gpio_pkg::data_t'(gpio_out), v & PIN_MASK);
      @(posedge clk);
      bus_read(`GPIO_OUT, rd);
      check_value("OUT read", rd, v & PIN_MASK);
      v = rand_bits(32);
      bus_write(`GPIO_IEN, v);
      bus_read(`GPIO_IEN, rd);
      check_value("IEN read", rd, v & PIN_MASK);
      v = rand_bits(32);
      bus_write(`GPIO_IMASK, v);
      bus_read(`GPIO_IMASK, rd);
      check_value("IMASK read", rd, v & PIN_MASK);
      // Aliases and unused words
      for (int i = 4; i < 16; i++) begin
         if (i != 7) begin
            bus_read(gpio_pkg::regidx_t'(i), rd);
            check_value($sformatf("read of index %0d", i), rd, 0);
         end
      end
   endtask

   task automatic test_aliases;
      gpio_pkg::data_t   model;
      gpio_pkg::data_t   d;
      gpio_pkg::data_t   sel;
      gpio_pkg::regidx_t idx;
      model = rand_bits(24);
      bus_write(`GPIO_OUT, model);
      repeat (9) begin
         sel = rand_bits(2) % 3;
         d   = rand_bits(24);
         case (sel)
            32'd0: begin
               idx   = `GPIO_OUTAND;
               model = model & d;
            end
            32'd1: begin
               idx   = `GPIO_OUTORR;
               model = model | d;
            end
            default: begin
               idx   = `GPIO_OUTXOR;
               model = model ^ d;
            end
         endcase
         bus_write(idx, d);
         @(negedge clk);
         check_value("gpio_out", gpio_pkg::data_t'(gpio_out), model);
         @(posedge clk);
      end
   endtask

   task automatic test_input;
      gpio_pkg::data_t en;
      gpio_pkg::data_t pins;
      gpio_pkg::data_t rd;
      // Full enable first, then a random partial one
      en = PIN_MASK;
      for (int round = 0; round < 2; round++) begin
         bus_write(`GPIO_IEN, en);
         pins = rand_bits(24);
         gpio_in <= pins[23:0];
         repeat (4) @(posedge clk);
         @(negedge clk);
         check_value("gpio_data", gpio_pkg::data_t'(gpio_data), pins & en);
         @(posedge clk);
         bus_read(`GPIO_IN, rd);
         check_value("IN read", rd, pins & en);
         en = rand_bits(24);
      end
   endtask

   task automatic test_irq;
      gpio_pkg::data_t sel;
      int              b;
      int              hits;
      sel = rand_bits(5) % 24;
      b   = int'(sel);
      bus_write(`GPIO_IMASK, 0);
      bus_write(`GPIO_IEN, PIN_MASK);
      repeat (6) @(posedge clk);
      toggle_pin(b, hits);
      check_value("gpio_irq pulses, unmasked", gpio_pkg::data_t'(hits), 1);
      bus_write(`GPIO_IMASK, 32'd1 << b);
      toggle_pin(b, hits);
      check_value("gpio_irq pulses, masked", gpio_pkg::data_t'(hits), 0);
      // Disabling the pin may itself toggle the gated value, let it settle
      bus_write(`GPIO_IMASK, 0);
      bus_write(`GPIO_IEN, PIN_MASK & ~(32'd1 << b));
      repeat (6) @(posedge clk);
      toggle_pin(b, hits);
      check_value("gpio_irq pulses, disabled", gpio_pkg::data_t'(hits), 0);
      bus_write(`GPIO_IEN, PIN_MASK);
   endtask

   task automatic test_backpressure;
      gpio_pkg::data_t a;
      gpio_pkg::data_t c;
      gpio_pkg::data_t first;
      a = rand_bits(24);
      c = rand_bits(24);
      bus_write(`GPIO_OUT, a);
      bus_write(`GPIO_IMASK, c);
      wait_in   <= 1'b1;
      access_in <= 1'b1;
      write_in  <= 1'b0;
      addr_in   <= addr_of(`GPIO_OUT);
      wait_accept();
      // Second read queued behind the blocked response
      addr_in <= addr_of(`GPIO_IMASK);
      repeat (3) begin
         @(negedge clk);
         check_value("access_out, blocked", gpio_pkg::data_t'(access_out), 1);
         check_value("data_out, blocked", data_out, a);
         check_value("wait_out, blocked", gpio_pkg::data_t'(wait_out), 1);
         @(posedge clk);
      end
      wait_in <= 1'b0;
      @(negedge clk);
      check_value("wait_out, released", gpio_pkg::data_t'(wait_out), 0);
      check_value("access_out, first", gpio_pkg::data_t'(access_out), 1);
      first = data_out;
      @(posedge clk);
      access_in <= 1'b0;
      @(negedge clk);
      check_value("access_out, second", gpio_pkg::data_t'(access_out), 1);
      check_value("first response", first, a);
      check_value("second response", data_out, c);
      @(posedge clk);
   endtask

   // ##################################################
   // Sequence and watchdog
   // ##################################################

   initial begin
      clk = 1'b0;
      nreset    <= 1'b0;
      access_in <= 1'b0;
      write_in  <= 1'b0;
      addr_in   <= '0;
      data_in   <= '0;
      wait_in   <= 1'b0;
      gpio_in   <= '0;
      repeat (3) @(posedge clk);
      nreset <= 1'b1;
      @(posedge clk);
      mark = errors;
      test_reset();
      report_test("reset values", mark);
      mark = errors;
      test_readback();
      report_test("write and read back", mark);
      mark = errors;
      test_aliases();
      report_test("output aliases", mark);
      mark = errors;
      test_input();
      report_test("input path", mark);
      mark = errors;
      test_irq();
      report_test("interrupt", mark);
      mark = errors;
      test_backpressure();
      report_test("back-pressure", mark);
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Six tests of at most 200 cycles, with margin
   initial begin
      #40000;
      $display("Timeout, the run did not finish within 40 us");
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== verilog/gpio.sv ====
// GPIO block top level, joins the access sequencer, register file and input path to plain ports
`timescale 1ns/1ns

module gpio #(
   parameter int N = 24
) (
   input  logic              clk,
   input  logic              nreset,
   // ##################################################
   // Request handshake
   // ##################################################
   input  logic              access_in,
   input  logic              write_in,
   input  gpio_pkg::addr_t   addr_in,
   input  gpio_pkg::data_t   data_in,
   output logic              wait_out,
   // ##################################################
   // Response handshake
   // ##################################################
   output logic              access_out,
   output gpio_pkg::data_t   data_out,
   input  logic              wait_in,
   // ##################################################
   // Pins
   // ##################################################
   input  logic [N-1:0]      gpio_in,
   output logic [N-1:0]      gpio_out,
   // Active low output enables
   output logic [N-1:0]      gpio_oen,
   // Synchronized and gated pins
   output logic [N-1:0]      gpio_data,
   // One-cycle toggle interrupt
   output logic              gpio_irq
);

   // Register path between sequencer and register file
   gpio_bus_if bus ();

   // Register file to input path and back
   gpio_pkg::data_t in_data;
   gpio_pkg::data_t ien;
   gpio_pkg::data_t imask;

   gpio_access u_access (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .write_in   (write_in),
      .addr_in    (addr_in),
      .data_in    (data_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .data_out   (data_out),
      .wait_in    (wait_in),
      .bus        (bus.sequencer)
   );

   gpio_regs #(.N(N)) u_regs (
      .clk      (clk),
      .nreset   (nreset),
      .bus      (bus.regfile),
      .in_data  (in_data),
      .ien      (ien),
      .imask    (imask),
      .gpio_out (gpio_out),
      .gpio_oen (gpio_oen)
   );

   gpio_input #(.N(N)) u_input (
      .clk       (clk),
      .nreset    (nreset),
      .gpio_in   (gpio_in),
      .ien       (ien),
      .imask     (imask),
      .in_data   (in_data),
      .gpio_data (gpio_data),
      .gpio_irq  (gpio_irq)
   );

endmodule

// ==== verilog/gpio_access.sv ====
// Access sequencer of the GPIO block, turns port requests into register strobes and holds read responses
`timescale 1ns/1ns

module gpio_access (
   input  logic                clk,
   input  logic                nreset,
   // Request side
   input  logic                access_in,
   input  logic                write_in,
   input  gpio_pkg::addr_t     addr_in,
   input  gpio_pkg::data_t     data_in,
   output logic                wait_out,
   // Response side
   output logic                access_out,
   output gpio_pkg::data_t     data_out,
   input  logic                wait_in,
   // Register bus
   gpio_bus_if.sequencer       bus
);

   gpio_pkg::access_state_t state;
   gpio_pkg::access_state_t state_next;
   logic                    accept;
   logic                    read_accept;
   gpio_pkg::data_t         resp_data;

   // ##################################################
   // Request acceptance
   // ##################################################

   // Stall only while a response is blocked downstream
   assign wait_out = (state == gpio_pkg::RESP) & wait_in;

   // Request taken on this edge
   assign accept      = access_in & ~wait_out;
   assign read_accept = accept & ~write_in;

   // Strobes to the register file
   assign bus.wr    = accept & write_in;
   assign bus.rd    = read_accept;
   // Word index, byte offset bits dropped
   assign bus.idx   = addr_in[5:2];
   assign bus.wdata = data_in;

   // ##################################################
   // State machine
   // ##################################################

   always_comb begin
      state_next = state;
      case (state)
         gpio_pkg::IDLE: begin
            // Writes give no response
            if (read_accept)
               state_next = gpio_pkg::RESP;
         end
         gpio_pkg::RESP: begin
            // Response consumed, a new read may follow on the same edge
            if (!wait_in)
               state_next = read_accept ? gpio_pkg::RESP : gpio_pkg::IDLE;
         end
         default: state_next = gpio_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         state <= gpio_pkg::IDLE;
      else
         state <= state_next;
   end

   // ##################################################
   // Response register
   // ##################################################

   // Capture register value as of the accepting edge
   always_ff @(posedge clk) begin
      if (read_accept)
         resp_data <= bus.rdata;
   end

   assign access_out = (state == gpio_pkg::RESP);
   assign data_out   = resp_data;

   // Back-pressure only comes from a pending response
   a_no_wait_in_idle: assert property (@(posedge clk) disable iff (!nreset)
      (state == gpio_pkg::IDLE) |-> !wait_out);

   // Blocked response holds its payload
   a_resp_stable: assert property (@(posedge clk) disable iff (!nreset)
      (access_out && wait_in) |=> $stable(data_out));

endmodule

// ==== verilog/gpio_bus_if.sv ====
// Internal register bus from the access sequencer to the register file, one operation per cycle
`timescale 1ns/1ns

interface gpio_bus_if;

   // Single-cycle strobes, never both high
   logic                wr;
   logic                rd;
   // Target register word
   gpio_pkg::regidx_t   idx;
   // Write payload
   gpio_pkg::data_t     wdata;
   // Combinational read value for idx
   gpio_pkg::data_t     rdata;

   // Request side
   modport sequencer (
      output wr, rd, idx, wdata,
      input  rdata
   );

   // Register side
   modport regfile (
      input  wr, rd, idx, wdata,
      output rdata
   );

endinterface

// ==== verilog/gpio_input.sv ====
// GPIO input path with two-stage synchronizer, input enable gating and toggle interrupt
`timescale 1ns/1ns

module gpio_input #(
   parameter int N = 24
) (
   input  logic              clk,
   input  logic              nreset,
   // Raw pins
   input  logic [N-1:0]      gpio_in,
   // Controls from the register file
   input  gpio_pkg::data_t   ien,
   input  gpio_pkg::data_t   imask,
   // Readback word for GPIO_IN
   output gpio_pkg::data_t   in_data,
   output logic [N-1:0]      gpio_data,
   output logic              gpio_irq
);

   logic [N-1:0] sync_q1;
   logic [N-1:0] sync_q2;
   logic [N-1:0] gated_q;
   logic [N-1:0] prev_q;
   logic [N-1:0] edge_vec;
   logic         irq_q;

   // ##################################################
   // Synchronizer and gating
   // ##################################################

   // Two flops, then enable gating in a third
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         gated_q <= '0;
         prev_q  <= '0;
      end else begin
         sync_q1 <= gpio_in;
         sync_q2 <= sync_q1;
         gated_q <= sync_q2 & ien[N-1:0];
         // Last cycle's gated value for toggle detect
         prev_q  <= gated_q;
      end
   end

   assign gpio_data = gated_q;

   always_comb begin
      in_data        = '0;
      in_data[N-1:0] = gated_q;
   end

   // ##################################################
   // Toggle interrupt
   // ##################################################

   // Either direction, masked bits dropped
   assign edge_vec = (gated_q ^ prev_q) & ~imask[N-1:0];

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         irq_q <= 1'b0;
      else
         irq_q <= |edge_vec;
   end

   assign gpio_irq = irq_q;

   a_irq_cause: assert property (@(posedge clk) disable iff (!nreset)
      gpio_irq |-> $past(gated_q != prev_q));

endmodule

// ==== verilog/gpio_pkg.sv ====
// Shared types and limits of the GPIO block, referenced by scoped names in every module
package gpio_pkg;

   // ##################################################
   // Widths
   // ##################################################

   // Largest supported pin count
   localparam int MAX_PINS = 32;

   // Register and pin data word
   typedef logic [31:0] data_t;

   // Byte address on the access port
   typedef logic [7:0] addr_t;

   // Register word index, address bits 5 to 2
   typedef logic [3:0] regidx_t;

   // ##################################################
   // Access sequencer
   // ##################################################

   // IDLE   ready for a new request
   // RESP   read response held on the output
   typedef enum logic [0:0] {
      IDLE = 1'b0,
      RESP = 1'b1
   } access_state_t;

endpackage

// ==== verilog/gpio_regs.sv ====
// GPIO register file with output, enable and mask registers, output write aliases and read mux
`timescale 1ns/1ns
`include "gpio_regmap.svh"

module gpio_regs #(
   parameter int N = 24
) (
   input  logic              clk,
   input  logic              nreset,
   // Register bus from the sequencer
   gpio_bus_if.regfile       bus,
   // Gated input data from the input path
   input  gpio_pkg::data_t   in_data,
   // Controls to the input path
   output gpio_pkg::data_t   ien,
   output gpio_pkg::data_t   imask,
   // Pin drivers
   output logic [N-1:0]      gpio_out,
   output logic [N-1:0]      gpio_oen
);

   logic [N-1:0] oen_reg;
   logic [N-1:0] out_reg;
   logic [N-1:0] ien_reg;
   logic [N-1:0] imask_reg;
   logic [N-1:0] wdata_n;
   logic [N-1:0] out_next;
   logic         out_write;

   // Pin count out of range
   if (N < 1 || N > gpio_pkg::MAX_PINS) begin : g_bad_n
      $error("gpio_regs: N must be 1 to %0d", gpio_pkg::MAX_PINS);
   end

   // Only the pin bits of the write word matter
   assign wdata_n = bus.wdata[N-1:0];

   // ##################################################
   // Output data and aliases
   // ##################################################

   always_comb begin
      out_write = bus.wr;
      out_next  = out_reg;
      case (bus.idx)
         `GPIO_OUT:    out_next = wdata_n;
         `GPIO_OUTAND: out_next = out_reg & wdata_n;
         `GPIO_OUTORR: out_next = out_reg | wdata_n;
         `GPIO_OUTXOR: out_next = out_reg ^ wdata_n;
         default:      out_write = 1'b0;
      endcase
   end

   // ##################################################
   // Register writes
   // ##################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         // Pins float after reset
         oen_reg   <= '1;
         out_reg   <= '0;
         ien_reg   <= '1;
         imask_reg <= '0;
      end else begin
         if (out_write)
            out_reg <= out_next;
         // GPIO_IN and unused words ignore writes
         if (bus.wr && bus.idx == `GPIO_OEN)
            oen_reg <= wdata_n;
         if (bus.wr && bus.idx == `GPIO_IEN)
            ien_reg <= wdata_n;
         if (bus.wr && bus.idx == `GPIO_IMASK)
            imask_reg <= wdata_n;
      end
   end

   assign gpio_out = out_reg;
   assign gpio_oen = oen_reg;

   // Zero-extended controls
   always_comb begin
      ien          = '0;
      ien[N-1:0]   = ien_reg;
      imask        = '0;
      imask[N-1:0] = imask_reg;
   end

   // ##################################################
   // Read mux
   // ##################################################

   // Aliases and unused words read zero
   always_comb begin
      bus.rdata = '0;
      case (bus.idx)
         `GPIO_OEN:   bus.rdata[N-1:0] = oen_reg;
         `GPIO_OUT:   bus.rdata[N-1:0] = out_reg;
         `GPIO_IEN:   bus.rdata[N-1:0] = ien_reg;
         `GPIO_IN:    bus.rdata        = in_data;
         `GPIO_IMASK: bus.rdata[N-1:0] = imask_reg;
         default:     bus.rdata        = '0;
      endcase
   end

   // Sequencer never issues read and write at once
   a_one_strobe: assert property (@(posedge clk) disable iff (!nreset)
      !(bus.wr && bus.rd));

endmodule
